// File: Bender.yml
package:
  name: clkrst_gen

sources:
  - hw/clkrst_pkg.sv
  - hw/domain_cfg_if.sv
  - hw/clkrst_cfg_regs.sv
  - hw/clk_domain_gen.sv
  - hw/clkrst_out_stage.sv
  - hw/clkrst_gen_top.sv
  - target: test
    files:
      - verif/clkrst_sva.sv
      - verif/clkrst_tb.sv

// File: hw/clk_domain_gen.sv
// One domain: divide counter, enable strobe and reset sequencer
// dm_rst_i is assumed synchronous to clk
// A new divider is taken only at a period boundary, so no strobe is ever shortened
`default_nettype none

module clk_domain_gen #(
  parameter int unsigned DOMAIN_IDX = 0  // Selects the bit of DM_RST_MASK
) (
  input  wire          clk,
  input  wire          reset_i,
  input  wire          dm_rst_i,
  domain_cfg_if.dom_mp cfg_i,
  output logic         clk_en_o,
  output logic         rst_o
);

  // Whether the debug reset reaches this domain
  localparam logic DM_SEL = clkrst_pkg::DM_RST_MASK[DOMAIN_IDX];

  logic                              rst_cause;
  logic                              dom_rst;
  logic [clkrst_pkg::RST_CNT_W-1:0]  stretch_q;

  logic [clkrst_pkg::DIV_W-1:0]      cnt_q;
  logic [clkrst_pkg::DIV_W-1:0]      cur_div_q;
  logic [clkrst_pkg::DIV_W-1:0]      last_cnt;
  logic [clkrst_pkg::DIV_W-1:0]      new_div;
  logic                              strobe;

  // Reset sequencer

  assign rst_cause = reset_i | cfg_i.srst | (dm_rst_i & DM_SEL);

  // Reloads while the cause is on, then counts down to zero
  always_ff @(posedge clk) begin
    if (rst_cause) begin
      stretch_q <= clkrst_pkg::RST_CNT_W'(clkrst_pkg::RST_STAGES);
    end else if (stretch_q != '0) begin
      stretch_q <= stretch_q - clkrst_pkg::RST_CNT_W'(1);
    end
  end

  assign dom_rst = rst_cause | (stretch_q != '0); // On for RST_STAGES cycles past the cause

  // Divider

  assign last_cnt = cur_div_q - clkrst_pkg::DIV_W'(1);
  assign new_div  = (cfg_i.div == '0) ? clkrst_pkg::DIV_W'(1) : cfg_i.div;

  // One strobe per period, none while gated or in reset
  assign strobe = ~dom_rst & ~cfg_i.gate & (cnt_q == last_cnt);

  // Current divider only changes at the boundary
  always_ff @(posedge clk) begin
    if (reset_i) begin
      cur_div_q <= clkrst_pkg::DEFAULT_DIV;
    end else if (strobe && cfg_i.div_valid) begin
      cur_div_q <= new_div;
    end
  end

  always_ff @(posedge clk) begin
    if (dom_rst) begin
      cnt_q <= '0;
    end else if (strobe) begin
      cnt_q <= '0;                            // Next period starts, possibly with a new divider
    end else if (!cfg_i.gate) begin
      cnt_q <= cnt_q + clkrst_pkg::DIV_W'(1); // Gate freezes the count
    end
  end

  assign cfg_i.div_ready = strobe;
  assign clk_en_o        = strobe;
  assign rst_o           = dom_rst;

endmodule

`default_nettype wire

// File: hw/clkrst_cfg_regs.sv
// Config bus slave for dividers, gate mask and soft reset mask
// Master holds req/addr/wdata/web until ack and drops req the cycle after ack
// Writes take effect at the end of the ack cycle, undefined addresses read zero
`default_nettype none

module clkrst_cfg_regs (
  input  wire                             clk,
  input  wire                             reset_i,
  input  wire                             req_i,
  input  wire                             web_i,   // Low means write
  input  wire [clkrst_pkg::ADDR_W-1:0]    addr_i,
  input  wire [clkrst_pkg::DATA_W-1:0]    wdata_i,
  output logic                            ack_o,
  output logic [clkrst_pkg::DATA_W-1:0]   rdata_o,
  domain_cfg_if.cfg_mp                    cfg_o [clkrst_pkg::NUM_DOMAINS]
);

  logic                                ack_q;
  logic                                acc_start;
  logic                                wr_en;
  logic [clkrst_pkg::DATA_W-1:0]       rd_data;
  logic [clkrst_pkg::DIV_W-1:0]        div_q [clkrst_pkg::NUM_DOMAINS];
  logic [clkrst_pkg::NUM_DOMAINS-1:0]  div_valid_q;
  logic [clkrst_pkg::NUM_DOMAINS-1:0]  div_ready;
  logic [clkrst_pkg::NUM_DOMAINS-1:0]  gate_q;
  logic [clkrst_pkg::NUM_DOMAINS-1:0]  srst_q;

  assign acc_start = req_i & ~ack_q;          // First cycle of a request
  assign wr_en     = ack_q & req_i & ~web_i;  // Write lands at the end of ack

  // One-cycle ack pulse
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc_start;
    end
  end

  // Read mux, unused bits stay zero
  always_comb begin
    rd_data = '0;
    for (int i = 0; i < clkrst_pkg::NUM_DOMAINS; i++) begin
      if (addr_i == clkrst_pkg::ADDR_W'(i)) rd_data[clkrst_pkg::DIV_W-1:0] = div_q[i];
    end
    if (addr_i == clkrst_pkg::ADDR_GATE) rd_data[clkrst_pkg::NUM_DOMAINS-1:0] = gate_q;
    if (addr_i == clkrst_pkg::ADDR_SRST) rd_data[clkrst_pkg::NUM_DOMAINS-1:0] = srst_q;
  end

  // Sampled on the first request cycle, presented with ack
  always_ff @(posedge clk) begin
    if (acc_start) rdata_o <= rd_data;
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      div_valid_q <= '0;
      gate_q      <= '0;
      srst_q      <= '0;
      for (int i = 0; i < clkrst_pkg::NUM_DOMAINS; i++) begin
        div_q[i] <= clkrst_pkg::DEFAULT_DIV;
      end
    end else begin
      for (int i = 0; i < clkrst_pkg::NUM_DOMAINS; i++) begin
        if (wr_en && addr_i == clkrst_pkg::ADDR_W'(i)) begin
          div_q[i]       <= wdata_i[clkrst_pkg::DIV_W-1:0];
          div_valid_q[i] <= 1'b1; // Overwrites any pending update
        end else if (div_ready[i]) begin
          div_valid_q[i] <= 1'b0; // Taken by the domain
        end
      end
      if (wr_en && addr_i == clkrst_pkg::ADDR_GATE) begin
        gate_q <= wdata_i[clkrst_pkg::NUM_DOMAINS-1:0];
      end
      if (wr_en && addr_i == clkrst_pkg::ADDR_SRST) begin
        srst_q <= wdata_i[clkrst_pkg::NUM_DOMAINS-1:0];
      end
    end
  end

  // Fan out to the per-domain interfaces
  for (genvar i = 0; i < clkrst_pkg::NUM_DOMAINS; i++) begin : g_dom_if
    assign cfg_o[i].div       = div_q[i];
    assign cfg_o[i].div_valid = div_valid_q[i];
    assign cfg_o[i].gate      = gate_q[i];
    assign cfg_o[i].srst      = srst_q[i];
    assign div_ready[i]       = cfg_o[i].div_ready;
  end

  assign ack_o = ack_q;

endmodule

`default_nettype wire

// File: hw/clkrst_gen_top.sv
// Clock-enable and reset generator top level
// All outputs are in the clk domain, clk_en_o is a strobe and not a clock
// Config bus: hold req until the one-cycle ack, drop it the cycle after
`default_nettype none

module clkrst_gen_top (
  input  wire                                clk,
  input  wire                                reset_i,
  input  wire                                test_mode_i,
  input  wire                                dm_rst_i,
  input  wire                                cfg_req_i,
  input  wire                                cfg_web_i,   // Low means write
  input  wire [clkrst_pkg::ADDR_W-1:0]       cfg_addr_i,
  input  wire [clkrst_pkg::DATA_W-1:0]       cfg_wdata_i,
  output logic                               cfg_ack_o,
  output logic [clkrst_pkg::DATA_W-1:0]      cfg_rdata_o,
  output logic [clkrst_pkg::NUM_DOMAINS-1:0] clk_en_o,
  output logic [clkrst_pkg::NUM_DOMAINS-1:0] rst_o,
  output logic                               rst_done_o
);

  logic [clkrst_pkg::NUM_DOMAINS-1:0] dom_en;
  logic [clkrst_pkg::NUM_DOMAINS-1:0] dom_rst;

  domain_cfg_if dom_cfg [clkrst_pkg::NUM_DOMAINS] ();

  clkrst_cfg_regs u_cfg_regs (
    .clk     ( clk         ),
    .reset_i ( reset_i     ),
    .req_i   ( cfg_req_i   ),
    .web_i   ( cfg_web_i   ),
    .addr_i  ( cfg_addr_i  ),
    .wdata_i ( cfg_wdata_i ),
    .ack_o   ( cfg_ack_o   ),
    .rdata_o ( cfg_rdata_o ),
    .cfg_o   ( dom_cfg     )
  );

  for (genvar i = 0; i < clkrst_pkg::NUM_DOMAINS; i++) begin : g_domain
    clk_domain_gen #(
      .DOMAIN_IDX ( i )
    ) u_domain (
      .clk      ( clk        ),
      .reset_i  ( reset_i    ),
      .dm_rst_i ( dm_rst_i   ),
      .cfg_i    ( dom_cfg[i] ),
      .clk_en_o ( dom_en[i]  ),
      .rst_o    ( dom_rst[i] )
    );
  end

  clkrst_out_stage u_out_stage (
    .clk         ( clk         ),
    .reset_i     ( reset_i     ),
    .test_mode_i ( test_mode_i ),
    .en_i        ( dom_en      ),
    .rst_i       ( dom_rst     ),
    .clk_en_o    ( clk_en_o    ),
    .rst_o       ( rst_o       ),
    .rst_done_o  ( rst_done_o  )
  );

endmodule

`default_nettype wire

// File: hw/clkrst_out_stage.sv
// Output register stage for all domain enables and resets
// Test mode forces every enable high one cycle after it is raised
// rst_done_o is sticky until the next reset_i
`default_nettype none

module clkrst_out_stage (
  input  wire                                clk,
  input  wire                                reset_i,
  input  wire                                test_mode_i,
  input  wire [clkrst_pkg::NUM_DOMAINS-1:0]  en_i,
  input  wire [clkrst_pkg::NUM_DOMAINS-1:0]  rst_i,
  output logic [clkrst_pkg::NUM_DOMAINS-1:0] clk_en_o,
  output logic [clkrst_pkg::NUM_DOMAINS-1:0] rst_o,
  output logic                               rst_done_o
);

  logic [clkrst_pkg::NUM_DOMAINS-1:0] en_q;
  logic [clkrst_pkg::NUM_DOMAINS-1:0] rst_q;
  logic [clkrst_pkg::NUM_DOMAINS-1:0] tm_mask;
  logic                               done_q;

  assign tm_mask = {clkrst_pkg::NUM_DOMAINS{test_mode_i}};

  // Enables
  always_ff @(posedge clk) begin
    if (reset_i) begin
      en_q <= tm_mask;          // Off in reset unless in test mode
    end else begin
      en_q <= en_i | tm_mask;
    end
  end

  // Resets come up asserted
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rst_q <= '1;
    end else begin
      rst_q <= rst_i;
    end
  end

  // Set once all registered resets are released
  always_ff @(posedge clk) begin
    if (reset_i) begin
      done_q <= 1'b0;
    end else if (rst_q == '0) begin
      done_q <= 1'b1;
    end
  end

  assign clk_en_o   = en_q;
  assign rst_o      = rst_q;
  assign rst_done_o = done_q;

endmodule

`default_nettype wire

// File: hw/clkrst_pkg.sv
// Shared constants of the clock-enable and reset generator
// All domains run from the one system clock, a domain "clock" is an enable strobe
// Divider and mask registers sit on a small req/ack config bus
`default_nettype none

package clkrst_pkg;

  // Domain count, domain 0 is the core
  localparam int unsigned NUM_DOMAINS = 4;

  // Divider register width, value 0 behaves like 1
  localparam int unsigned DIV_W = 8;

  // Config bus widths
  localparam int unsigned ADDR_W = 4;
  localparam int unsigned DATA_W = 32;

  localparam logic [DIV_W-1:0] DEFAULT_DIV = 8'd1; // Enable always on after reset

  // Extra cycles a domain reset is held after its cause goes away
  localparam int unsigned RST_STAGES = 3;
  localparam int unsigned RST_CNT_W  = $clog2(RST_STAGES + 1);

  // Debug module reset only hits the core domain
  localparam logic [NUM_DOMAINS-1:0] DM_RST_MASK = 4'b0001;

  // Register map
  // Addresses 0 .. NUM_DOMAINS-1 hold the dividers
  localparam logic [ADDR_W-1:0] ADDR_GATE = 4'd4; // One gate bit per domain
  localparam logic [ADDR_W-1:0] ADDR_SRST = 4'd5; // One soft reset bit per domain

endpackage

`default_nettype wire

// File: hw/domain_cfg_if.sv
// Per-domain control from the config block to one domain block
// div/div_valid/div_ready form a lossy update: a newer write replaces a pending one
// gate and srst are plain levels
`default_nettype none

interface domain_cfg_if;

  logic [clkrst_pkg::DIV_W-1:0] div; // Raw written value, 0 is mapped to 1 by the domain
  logic                         div_valid;
  logic                         div_ready; // High at the period boundary
  logic                         gate;
  logic                         srst;

  // Config register side
  modport cfg_mp (
    output div,
    output div_valid,
    output gate,
    output srst,
    input  div_ready
  );

  // Domain side
  modport dom_mp (
    input  div,
    input  div_valid,
    input  gate,
    input  srst,
    output div_ready
  );

endinterface

`default_nettype wire

// File: verif/clkrst_sva.sv
// Protocol and reset assertions, bound to the generator top level
// Enables are forced by test mode one cycle late, so the cycle after it drops is exempt
`default_nettype none

module clkrst_sva (
  input wire                               clk,
  input wire                               reset_i,
  input wire                               test_mode_i,
  input wire                               ack_i,
  input wire [clkrst_pkg::NUM_DOMAINS-1:0] clk_en_i,
  input wire [clkrst_pkg::NUM_DOMAINS-1:0] rst_i,
  input wire                               rst_done_i
);

  // Ack is a single-cycle pulse
  ack_pulse: assert property (@(posedge clk) disable iff (reset_i) ack_i |=> !ack_i)
    else $error("config ack high for two cycles");

  // No enable strobe in a domain that is in reset
  en_in_reset: assert property (@(posedge clk) disable iff (reset_i)
    !(test_mode_i || $past(test_mode_i)) |-> (clk_en_i & rst_i) == '0)
    else $error("enable high while domain reset is on");

  done_sticky: assert property (@(posedge clk) rst_done_i && !reset_i |=> rst_done_i)
    else $error("reset done fell without reset");

endmodule

bind clkrst_gen_top clkrst_sva u_sva (
  .clk         ( clk         ),
  .reset_i     ( reset_i     ),
  .test_mode_i ( test_mode_i ),
  .ack_i       ( cfg_ack_o   ),
  .clk_en_i    ( clk_en_o    ),
  .rst_i       ( rst_o       ),
  .rst_done_i  ( rst_done_o  )
);

`default_nettype wire

// File: verif/clkrst_tb.sv
// Testbench for the clock-enable and reset generator
// Inputs change 10 units after the rising edge and the monitor samples on the falling edge
// Strobe spacing is compared with a reference of the written dividers
`default_nettype none

module clkrst_tb;

  localparam int ND = clkrst_pkg::NUM_DOMAINS;

  logic                          clk;
  logic                          reset_i;
  logic                          test_mode_i;
  logic                          dm_rst_i;
  logic                          cfg_req_i;
  logic                          cfg_web_i;
  logic [clkrst_pkg::ADDR_W-1:0] cfg_addr_i;
  logic [clkrst_pkg::DATA_W-1:0] cfg_wdata_i;
  logic                          cfg_ack_o;
  logic [clkrst_pkg::DATA_W-1:0] cfg_rdata_o;
  logic [ND-1:0]                 clk_en_o;
  logic [ND-1:0]                 rst_o;
  logic                          rst_done_o;

  integer seed = 90993;
  int n_checks = 0;
  int n_errors = 0;
  logic [clkrst_pkg::DIV_W-1:0] ref_div [ND]; // Register model
  logic [ND-1:0] ref_gate;
  logic [ND-1:0] ref_srst;
  logic meas_en = 1'b0;
  int gap [ND] = '{default: 0};
  int n_meas [ND] = '{default: 0};
  int n_strobe [ND] = '{default: 0};
  bit seen [ND] = '{default: 1'b0};

  clkrst_gen_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int expected_period(logic [clkrst_pkg::DIV_W-1:0] div);
    return (div == '0) ? 1 : int'(div);
  endfunction

  function automatic logic [31:0] ref_rdata(logic [clkrst_pkg::ADDR_W-1:0] addr);
    logic [31:0] data;
    data = '0;
    if (addr < ND) data[clkrst_pkg::DIV_W-1:0] = ref_div[addr];
    else if (addr == clkrst_pkg::ADDR_GATE) data[ND-1:0] = ref_gate;
    else if (addr == clkrst_pkg::ADDR_SRST) data[ND-1:0] = ref_srst;
    return data;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic advance(int n);
    repeat (n) @(posedge clk);
    #10; // Drive point
  endtask

  task automatic bus_access(bit write, logic [3:0] addr, logic [31:0] wdata,
                            output logic [31:0] rdata);
    int t;
    cfg_req_i   = 1'b1;
    cfg_web_i   = ~write;
    cfg_addr_i  = addr;
    cfg_wdata_i = wdata;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!cfg_ack_o && t < 20);
    if (!cfg_ack_o) begin
      n_errors++;
      $display("no ack from config bus");
    end else begin
      // Req is seen at the first edge, ack follows in the next cycle
      check_value("ack latency", 2, t);
    end
    rdata = cfg_rdata_o;
    advance(1);
    cfg_req_i = 1'b0; // Cycle after ack
  endtask

  task automatic bus_write(logic [3:0] addr, logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b1, addr, wdata, unused);
    if (addr < ND) ref_div[addr] = wdata[clkrst_pkg::DIV_W-1:0];
    else if (addr == clkrst_pkg::ADDR_GATE) ref_gate = wdata[ND-1:0];
    else if (addr == clkrst_pkg::ADDR_SRST) ref_srst = wdata[ND-1:0];
  endtask

  task automatic bus_read(logic [3:0] addr);
    logic [31:0] data;
    bus_access(1'b0, addr, '0, data);
    check_value($sformatf("read addr %0d", addr), ref_rdata(addr), data);
  endtask

  // Counts high cycles of the masked resets, returns on the falling edge where they are low
  task automatic rst_release_delay(logic [ND-1:0] mask, string name);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while ((rst_o & mask) != '0 && n < 20);
    check_value(name, 4, n - 1);
  endtask

  task automatic measure_periods(string name);
    int t;
    meas_en = 1'b1;
    for (int d = 0; d < ND; d++) begin
      t = 0;
      while (n_meas[d] < 3 && t < 100) begin
        advance(1);
        t++;
      end
      if (n_meas[d] < 3) begin
        n_errors++;
        $display("too few strobes in domain %0d during %s", d, name);
      end
    end
    meas_en = 1'b0;
  endtask

  task automatic strobes_in_window(int cycles, output logic [ND-1:0] active);
    int start [ND];
    for (int d = 0; d < ND; d++) start[d] = n_strobe[d];
    advance(cycles);
    for (int d = 0; d < ND; d++) active[d] = (n_strobe[d] != start[d]);
  endtask

  // Strobe spacing monitor
  always @(negedge clk) begin
    for (int d = 0; d < ND; d++) begin
      if (clk_en_o[d] === 1'b1) n_strobe[d]++;
      if (!meas_en) begin
        seen[d]   = 1'b0;
        gap[d]    = 0;
        n_meas[d] = 0;
      end else begin
        gap[d]++;
        if (clk_en_o[d] === 1'b1) begin
          if (seen[d]) begin
            check_value($sformatf("period dom%0d", d), expected_period(ref_div[d]), gap[d]);
            n_meas[d]++;
          end
          seen[d] = 1'b1;
          gap[d]  = 0;
        end
      end
    end
  end

  initial begin
    int old_max;
    logic [ND-1:0] active;
    reset_i     = 1'b1;
    test_mode_i = 1'b0;
    dm_rst_i    = 1'b0;
    cfg_req_i   = 1'b0;
    cfg_web_i   = 1'b1;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    ref_gate    = '0;
    ref_srst    = '0;
    for (int d = 0; d < ND; d++) ref_div[d] = clkrst_pkg::DEFAULT_DIV;

    // Reset release
    advance(5);
    check_value("rst in reset", {ND{1'b1}}, rst_o);
    check_value("en in reset", '0, clk_en_o);
    check_value("ack in reset", 0, cfg_ack_o);
    reset_i = 1'b0;
    rst_release_delay({ND{1'b1}}, "rst release");
    check_value("done before release", 0, rst_done_o);
    @(negedge clk);
    check_value("done after release", 1, rst_done_o);
    repeat (3) begin
      @(negedge clk);
      check_value("div1 enables", {ND{1'b1}}, clk_en_o);
    end
    advance(1);

    // Write all registers and read back every address
    for (int a = 0; a < ND; a++) bus_write(a, 32'hC3C3_C3C0 | a);
    bus_write(clkrst_pkg::ADDR_GATE, 32'h1234_5675);
    bus_write(clkrst_pkg::ADDR_SRST, 32'hFFFF_FFFA);
    bus_write(4'd9, 32'hFFFF_FFFF);
    for (int a = 0; a < 16; a++) bus_read(a);
    bus_write(clkrst_pkg::ADDR_GATE, 0);
    bus_write(clkrst_pkg::ADDR_SRST, 0);

    // Random dividers and a back-to-back double write
    old_max = 0;
    for (int d = 0; d < ND; d++) begin
      if (expected_period(ref_div[d]) > old_max) old_max = expected_period(ref_div[d]);
    end
    for (int d = 0; d < ND; d++) bus_write(d, $random(seed) & 15);
    advance(2 * old_max + 4);
    measure_periods("random div");
    bus_write(2, 7);
    bus_write(2, 3); // Last value wins
    advance(40);
    measure_periods("double write");

    // Gating
    bus_write(clkrst_pkg::ADDR_GATE, 4'b0100);
    advance(3);
    strobes_in_window(40, active);
    check_value("gate dom2", 4'b1011, active);
    bus_write(clkrst_pkg::ADDR_GATE, 0);
    advance(3);
    strobes_in_window(40, active);
    check_value("gate cleared", 4'b1111, active);

    // Soft reset and debug reset
    bus_write(clkrst_pkg::ADDR_SRST, 4'b0010);
    advance(2);
    check_value("srst dom1", 4'b0010, rst_o);
    bus_write(clkrst_pkg::ADDR_SRST, 0);
    rst_release_delay(4'b0010, "srst release");
    advance(1);
    dm_rst_i = 1'b1;
    advance(2);
    check_value("dm reset mask", clkrst_pkg::DM_RST_MASK, rst_o);
    dm_rst_i = 1'b0;
    rst_release_delay(clkrst_pkg::DM_RST_MASK, "dm reset release");
    advance(1);

    // Test mode overrides gate and divider
    bus_write(clkrst_pkg::ADDR_GATE, 4'b0101);
    test_mode_i = 1'b1;
    advance(1);
    repeat (4) begin
      check_value("test mode enables", {ND{1'b1}}, clk_en_o);
      advance(1);
    end
    test_mode_i = 1'b0;
    bus_write(clkrst_pkg::ADDR_GATE, 0);
    advance(5);

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hw/clkrst_pkg.sv
hw/domain_cfg_if.sv
hw/clkrst_cfg_regs.sv
hw/clk_domain_gen.sv
hw/clkrst_out_stage.sv
hw/clkrst_gen_top.sv
verif/clkrst_sva.sv
verif/clkrst_tb.sv
